// File: verilog.f
logic/msx_pkg.sv
logic/io_port_decoder.sv
logic/ppi_8255.sv
logic/slot_select.sv
logic/m1_wait_gen.sv
logic/audio_mixer.sv
logic/msx_glue_top.sv
+incdir+verification
verification/msx_glue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module msx_glue_tb -Mdir obj_dir \
   -f verilog.f -o msx_glue_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/msx_glue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   exit 1
fi
exit 0

// File: verification/msx_glue_model.svh
`ifndef MSX_GLUE_MODEL_SVH
`define MSX_GLUE_MODEL_SVH

// Expected PPI state, tracked from the accesses the testbench makes
msx_pkg::data_t model_port_a;
msx_pkg::data_t model_port_c;
logic           model_map_valid;

// I/O cycle without M1 that hits the eight-port group of port
function automatic logic model_io_hit(input msx_pkg::cpu_bus_t b, input logic [7:0] port);
   return b.iorq && !b.m1 && (b.addr[7:3] == port[7:3]);
endfunction

task automatic model_ppi_write(input logic [1:0] offset, input msx_pkg::data_t d);
   case (offset)
      2'd0: model_port_a = d;
      2'd2: model_port_c = d;
      2'd3: begin
         // Mode words leave port C alone
         if (!d[7]) begin
            model_port_c[d[3:1]] = d[0];
         end
      end
      default: begin
      end
   endcase
endtask

function automatic msx_pkg::data_t model_ppi_read(input logic [1:0] offset,
                                                  input msx_pkg::data_t kb);
   case (offset)
      2'd0:    return model_port_a;
      2'd1:    return kb;
      2'd2:    return model_port_c;
      default: return 8'hFF;
   endcase
endfunction

function automatic msx_pkg::slot_t model_slot(input logic [1:0] page);
   if (!model_map_valid) begin
      return 2'b00;
   end
   return 2'(model_port_a >> (2 * int'(page)));
endfunction

function automatic msx_pkg::data_t model_read_mux(input msx_pkg::cpu_bus_t b,
                                                  input msx_pkg::data_t vdp,
                                                  input msx_pkg::data_t psg,
                                                  input msx_pkg::data_t kb,
                                                  input msx_pkg::data_t mem);
   if (!b.rd) return 8'hFF;
   if (model_io_hit(b, 8'h98)) return vdp;
   if (model_io_hit(b, 8'hA0)) return psg;
   if (model_io_hit(b, 8'hA8)) return model_ppi_read(b.addr[1:0], kb);
   return mem;
endfunction

function automatic msx_pkg::sample_t model_audio(input msx_pkg::psg_level_t level,
                                                 input logic click, input logic cas,
                                                 input logic motor,
                                                 input msx_pkg::sample_t dev);
   int             p;
   int             s;
   msx_pkg::sample_t r;
   // PSG part wraps at the 10-bit level width
   p = (int'(level) + 32 * int'(click) + 16 * int'(cas & ~motor)) % 1024;
   s = p * 16 + int'(dev);
   if (s > 16383) return 16'h7FFF;
   if (s < -16384) return 16'h8000;
   r = 16'(s);
   r[0] = 1'b0;
   return r;
endfunction

`endif

// File: verification/msx_glue_tb.sv
module msx_glue_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CE_PERIOD     = 6;
   localparam int RESET_CYCLES  = 10;
   localparam int ACCESS_CYCLES = 4;
   localparam int SLOT_RUNS     = 8;
   localparam int PPI_RUNS      = 6;
   localparam int MUX_RUNS      = 40;
   localparam int VDP_RUNS      = 30;
   localparam int WAIT_RUNS     = 6;
   localparam int AUDIO_RUNS    = 10;
   localparam int TEST_CYCLES   = RESET_CYCLES
      + ACCESS_CYCLES * (4 + SLOT_RUNS * 5 + PPI_RUNS * 8 + MUX_RUNS + VDP_RUNS + AUDIO_RUNS)
      + WAIT_RUNS * 30 + AUDIO_RUNS * 8;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic                clk21m;
   logic                exwait_n;
   logic                ce_cpu_i;
   msx_pkg::cpu_bus_t   bus;
   msx_pkg::data_t      vdp_data;
   msx_pkg::data_t      psg_data;
   msx_pkg::data_t      kb_data;
   msx_pkg::data_t      mem_data;
   msx_pkg::psg_level_t psg_level;
   msx_pkg::sample_t    device_sound;
   logic                cas_audio;
   msx_pkg::data_t      cpu_data;
   logic                vdp_req;
   logic                wait_n;
   msx_pkg::slot_t      slot;
   msx_pkg::kb_row_t    kb_row;
   logic                cas_motor;
   msx_pkg::sample_t    audio;

   logic [31:0] rand_state;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_err_start;
   int          cycle_count;
   int          ce_cnt;
   int          req_count;
   int          low_cycles;
   int          wait_falls;
   logic        prev_wait_n;

   `include "msx_glue_model.svh"

   msx_glue_top msx_glue_top_inst (
      .clk21m         (clk21m),
      .exwait_n       (exwait_n),
      .ce_cpu_i       (ce_cpu_i),
      .cpu_bus_i      (bus),
      .vdp_data_i     (vdp_data),
      .psg_data_i     (psg_data),
      .kb_data_i      (kb_data),
      .mem_data_i     (mem_data),
      .psg_level_i    (psg_level),
      .device_sound_i (device_sound),
      .cas_audio_i    (cas_audio),
      .cpu_data_o     (cpu_data),
      .vdp_req_o      (vdp_req),
      .wait_n_o       (wait_n),
      .slot_o         (slot),
      .kb_row_o       (kb_row),
      .cas_motor_o    (cas_motor),
      .audio_o        (audio)
   );

   always #5 clk21m = ~clk21m;

   // CPU clock enable, one cycle in six
   always @(negedge clk21m) begin
      if (ce_cnt == CE_PERIOD - 1) begin
         ce_cnt   <= 0;
         ce_cpu_i <= 1'b1;
      end else begin
         ce_cnt   <= ce_cnt + 1;
         ce_cpu_i <= 1'b0;
      end
   end

   // Pulse and wait monitors, plus the run limit
   always @(posedge clk21m) begin
      cycle_count = cycle_count + 1;
      if (vdp_req) req_count = req_count + 1;
      if (!wait_n) low_cycles = low_cycles + 1;
      if (prev_wait_n && !wait_n) wait_falls = wait_falls + 1;
      prev_wait_n = wait_n;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
      checks = checks + 1;
      if (expected !== actual) begin
         errors = errors + 1;
         $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   task end_test(input string name);
      tests_run = tests_run + 1;
      if (errors > test_err_start) begin
         tests_failed = tests_failed + 1;
         $display("%s: failed, %0d errors", name, errors - test_err_start);
      end else begin
         $display("%s: passed", name);
      end
      test_err_start = errors;
   endtask

   function msx_pkg::cpu_bus_t io_bus(input logic [7:0] port, input logic wr,
                                      input msx_pkg::data_t d);
      msx_pkg::cpu_bus_t b;
      b      = '0;
      b.addr = {8'h00, port};
      b.iorq = 1'b1;
      b.wr   = wr;
      b.rd   = !wr;
      b.dout = d;
      return b;
   endfunction

   function msx_pkg::cpu_bus_t mem_read_bus(input msx_pkg::addr_t a);
      msx_pkg::cpu_bus_t b;
      b      = '0;
      b.addr = a;
      b.mreq = 1'b1;
      b.rd   = 1'b1;
      return b;
   endfunction

   // Drive an access and hold it; caller checks at the last falling edge
   task start_access(input msx_pkg::cpu_bus_t acc);
      @(negedge clk21m);
      bus = acc;
      if (model_io_hit(acc, 8'hA8)) begin
         model_map_valid = 1'b1;
         if (acc.wr) model_ppi_write(acc.addr[1:0], acc.dout);
      end
      repeat (2) @(negedge clk21m);
   endtask

   task end_access();
      bus = '0;
      @(negedge clk21m);
   endtask

   task test_slot_mapping();
      logic [31:0] rnd;
      for (int p = 0; p < 4; p++) begin
         start_access(mem_read_bus(16'(p) << 14));
         check_value("slot_reset", 32'(model_slot(2'(p))), 32'(slot));
         end_access();
      end
      for (int r = 0; r < SLOT_RUNS; r++) begin
         rnd = next_rand();
         start_access(io_bus(8'hA8, 1'b1, rnd[31:24]));
         end_access();
         for (int p = 0; p < 4; p++) begin
            start_access(mem_read_bus({2'(p), rnd[13:0]}));
            check_value("slot_map", 32'(model_slot(2'(p))), 32'(slot));
            end_access();
         end
      end
      end_test("slot_mapping");
   endtask

   task test_ppi();
      logic [31:0]    rnd;
      msx_pkg::data_t d;
      for (int r = 0; r < PPI_RUNS; r++) begin
         for (int w = 0; w < 4; w++) begin
            rnd = next_rand();
            d   = rnd[23:16];
            if (rnd[31:30] == 2'd0) begin
               start_access(io_bus(8'hA8, 1'b1, d));
            end else if (rnd[31:30] == 2'd1) begin
               start_access(io_bus(8'hAA, 1'b1, d));
            end else begin
               start_access(io_bus(8'hAB, 1'b1, d));
            end
            end_access();
         end
         for (int off = 0; off < 4; off++) begin
            rnd     = next_rand();
            kb_data = rnd[31:24];
            start_access(io_bus(8'hA8 | 8'(off), 1'b0, 8'h00));
            check_value("ppi_read", 32'(model_ppi_read(2'(off), kb_data)), 32'(cpu_data));
            check_value("ppi_kb_row", 32'(model_port_c[3:0]), 32'(kb_row));
            check_value("ppi_cas_motor", 32'(model_port_c[4]), 32'(cas_motor));
            end_access();
         end
      end
      end_test("ppi_access");
   endtask

   task test_read_mux();
      logic [31:0]       rnd;
      logic [31:0]       src;
      logic [7:0]        port;
      msx_pkg::cpu_bus_t acc;
      for (int r = 0; r < MUX_RUNS; r++) begin
         rnd = next_rand();
         src = next_rand();
         case (rnd[1:0])
            2'd0:    port = {5'b10100, rnd[18:16]};
            2'd1:    port = {5'b10101, rnd[18:16]};
            2'd2:    port = {5'b10011, rnd[18:16]};
            default: port = rnd[15:8];
         endcase
         acc      = '0;
         acc.addr = {rnd[31:24], port};
         acc.iorq = rnd[2];
         acc.mreq = rnd[3];
         acc.rd   = rnd[4];
         acc.m1   = rnd[5];
         vdp_data = src[7:0];
         psg_data = src[15:8];
         kb_data  = src[23:16];
         mem_data = src[31:24];
         start_access(acc);
         check_value("read_mux",
                     32'(model_read_mux(acc, vdp_data, psg_data, kb_data, mem_data)),
                     32'(cpu_data));
         end_access();
      end
      end_test("read_mux");
   endtask

   task test_vdp_request();
      logic [31:0]       rnd;
      msx_pkg::cpu_bus_t acc;
      for (int r = 0; r < VDP_RUNS; r++) begin
         rnd = next_rand();
         case (rnd[1:0])
            2'd0:    acc = io_bus({5'b10011, rnd[10:8]}, 1'b0, 8'h00);
            2'd1:    acc = io_bus({5'b10011, rnd[10:8]}, 1'b1, rnd[23:16]);
            2'd2:    acc = io_bus({5'b10100, rnd[10:8]}, rnd[4], rnd[23:16]);
            default: begin
               acc    = mem_read_bus(rnd[31:16]);
               acc.rd = rnd[4];
               acc.wr = !rnd[4];
            end
         endcase
         req_count = 0;
         start_access(acc);
         end_access();
         check_value("vdp_req_count", (rnd[1:0] < 2'd2) ? 32'd1 : 32'd0, 32'(req_count));
      end
      end_test("vdp_request");
   endtask

   task test_wait();
      logic [31:0]       rnd;
      msx_pkg::cpu_bus_t acc;
      for (int r = 0; r < WAIT_RUNS; r++) begin
         rnd    = next_rand();
         acc    = mem_read_bus(rnd[31:16]);
         acc.m1 = 1'b1;
         @(negedge clk21m);
         low_cycles = 0;
         wait_falls = 0;
         bus        = acc;
         // Long enough to see two CPU clock strobes
         repeat (14 + int'(rnd[2:0])) @(negedge clk21m);
         bus = '0;
         repeat (8) @(negedge clk21m);
         check_value("wait_falls", 32'd1, 32'(wait_falls));
         check_value("wait_low_cycles", 32'(CE_PERIOD), 32'(low_cycles));
      end
      end_test("m1_wait");
   endtask

   task test_audio();
      logic [31:0]      rnd;
      msx_pkg::sample_t expected;
      for (int r = 0; r < AUDIO_RUNS; r++) begin
         rnd = next_rand();
         start_access(io_bus(8'hAA, 1'b1, rnd[31:24]));
         end_access();
         for (int i = 0; i < 4; i++) begin
            rnd = next_rand();
            @(negedge clk21m);
            psg_level = rnd[9:0];
            cas_audio = rnd[10];
            // Two samples per round push into each saturation limit
            if (i == 0) begin
               device_sound = 16'h7F00;
            end else if (i == 1) begin
               device_sound = 16'h8000;
            end else begin
               device_sound = rnd[31:16];
            end
            expected = model_audio(psg_level, model_port_c[7], cas_audio, model_port_c[4],
                                   device_sound);
            @(negedge clk21m);
            check_value("audio_sample", 32'(expected), 32'(audio));
         end
      end
      end_test("audio_mix");
   endtask

   initial begin
      clk21m          = 1'b0;
      exwait_n        = 1'b0;
      ce_cpu_i        = 1'b0;
      bus             = '0;
      vdp_data        = '0;
      psg_data        = '0;
      kb_data         = '0;
      mem_data        = '0;
      psg_level       = '0;
      device_sound    = '0;
      cas_audio       = 1'b0;
      rand_state      = 32'h3f38_5624;
      errors          = 0;
      checks          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      test_err_start  = 0;
      cycle_count     = 0;
      ce_cnt          = 0;
      req_count       = 0;
      low_cycles      = 0;
      wait_falls      = 0;
      prev_wait_n     = 1'b1;
      model_port_a    = '0;
      model_port_c    = '0;
      model_map_valid = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk21m);
      exwait_n = 1'b1;
      test_slot_mapping();
      test_ppi();
      test_read_mux();
      test_vdp_request();
      test_wait();
      test_audio();
      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: logic/msx_glue_top.sv
module msx_glue_top (
   input  logic                 clk21m,
   input  logic                 exwait_n,
   input  logic                 ce_cpu_i,
   input  msx_pkg::cpu_bus_t    cpu_bus_i,
   input  msx_pkg::data_t       vdp_data_i,
   input  msx_pkg::data_t       psg_data_i,
   input  msx_pkg::data_t       kb_data_i,
   input  msx_pkg::data_t       mem_data_i,
   input  msx_pkg::psg_level_t  psg_level_i,
   input  msx_pkg::sample_t     device_sound_i,
   input  logic                 cas_audio_i,
   output msx_pkg::data_t       cpu_data_o,
   output logic                 vdp_req_o,
   output logic                 wait_n_o,
   output msx_pkg::slot_t       slot_o,
   output msx_pkg::kb_row_t     kb_row_o,
   output logic                 cas_motor_o,
   output msx_pkg::sample_t     audio_o
);

   msx_pkg::io_sel_t   io_sel;
   msx_pkg::data_t     ppi_data;
   msx_pkg::data_t     port_a;
   msx_pkg::ppi_ctrl_t ppi_ctrl;

   io_port_decoder io_port_decoder_inst (
      .clk21m     (clk21m),
      .exwait_n   (exwait_n),
      .cpu_bus_i  (cpu_bus_i),
      .vdp_data_i (vdp_data_i),
      .psg_data_i (psg_data_i),
      .ppi_data_i (ppi_data),
      .mem_data_i (mem_data_i),
      .io_sel_o   (io_sel),
      .vdp_req_o  (vdp_req_o),
      .cpu_data_o (cpu_data_o)
   );

   ppi_8255 ppi_8255_inst (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .cpu_bus_i (cpu_bus_i),
      .sel_i     (io_sel.ppi),
      .kb_data_i (kb_data_i),
      .data_o    (ppi_data),
      .port_a_o  (port_a),
      .ctrl_o    (ppi_ctrl)
   );

   // Page is the top two CPU address bits
   slot_select slot_select_inst (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ppi_sel_i   (io_sel.ppi),
      .addr_page_i (cpu_bus_i.addr[15:14]),
      .port_a_i    (port_a),
      .slot_o      (slot_o)
   );

   m1_wait_gen m1_wait_gen_inst (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .ce_cpu_i (ce_cpu_i),
      .m1_i     (cpu_bus_i.m1),
      .wait_n_o (wait_n_o)
   );

   audio_mixer audio_mixer_inst (
      .clk21m         (clk21m),
      .exwait_n       (exwait_n),
      .psg_level_i    (psg_level_i),
      .key_click_i    (ppi_ctrl.key_click),
      .cas_audio_i    (cas_audio_i),
      .cas_motor_i    (ppi_ctrl.cas_motor),
      .device_sound_i (device_sound_i),
      .audio_o        (audio_o)
   );

   assign kb_row_o    = ppi_ctrl.kb_row;
   assign cas_motor_o = ppi_ctrl.cas_motor;

endmodule

// File: logic/audio_mixer.sv
module audio_mixer (
   input  logic                 clk21m,
   input  logic                 exwait_n,
   input  msx_pkg::psg_level_t  psg_level_i,
   input  logic                 key_click_i,
   input  logic                 cas_audio_i,
   input  logic                 cas_motor_i,
   input  msx_pkg::sample_t     device_sound_i,
   output msx_pkg::sample_t     audio_o
);

   msx_pkg::psg_level_t psg_part;
   logic [16:0]         psg_scaled;
   logic [16:0]         mix_sum;
   msx_pkg::sample_t    mix_sat;
   logic                cas_mon;

   // Cassette is monitored only while the motor is off
   assign cas_mon = cas_audio_i & ~cas_motor_i;

   assign psg_part = psg_level_i
                   + {4'b0000, key_click_i, 5'b00000}
                   + {5'b00000, cas_mon, 4'b0000};

   assign psg_scaled = {3'b000, psg_part, 4'b0000};
   assign mix_sum    = {device_sound_i[15], device_sound_i} + psg_scaled;

   // Top three bits tell whether the sum stays within range
   always_comb begin
      case (mix_sum[16:14])
         3'b000,
         3'b111: begin
            mix_sat = {mix_sum[15:1], 1'b0};
         end
         3'b001,
         3'b010,
         3'b011: begin
            mix_sat = 16'h7FFF;
         end
         default: begin
            mix_sat = 16'h8000;
         end
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         audio_o <= '0;
      end else begin
         audio_o <= mix_sat;
      end
   end

endmodule

// File: logic/m1_wait_gen.sv
module m1_wait_gen (
   input  logic clk21m,
   input  logic exwait_n,
   input  logic ce_cpu_i,
   input  logic m1_i,
   output logic wait_n_o
);

   msx_pkg::wait_state_t state;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         state <= msx_pkg::WAIT_IDLE;
      end else begin
         case (state)
            msx_pkg::WAIT_IDLE: begin
               if (ce_cpu_i && m1_i) begin
                  state <= msx_pkg::WAIT_HOLD;
               end
            end
            msx_pkg::WAIT_HOLD: begin
               // Exactly one CPU clock of wait
               if (ce_cpu_i) begin
                  state <= msx_pkg::WAIT_DONE;
               end
            end
            msx_pkg::WAIT_DONE: begin
               if (!m1_i) begin
                  state <= msx_pkg::WAIT_IDLE;
               end
            end
            default: begin
               state <= msx_pkg::WAIT_IDLE;
            end
         endcase
      end
   end

   assign wait_n_o = (state != msx_pkg::WAIT_HOLD);

endmodule

// File: logic/slot_select.sv
module slot_select (
   input  logic            clk21m,
   input  logic            exwait_n,
   input  logic            ppi_sel_i,
   input  logic [1:0]      addr_page_i,
   input  msx_pkg::data_t  port_a_i,
   output msx_pkg::slot_t  slot_o
);

   logic map_valid;

   // Slot map is trusted after the first PPI access
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         map_valid <= 1'b0;
      end else if (ppi_sel_i) begin
         map_valid <= 1'b1;
      end
   end

   always_comb begin
      if (!map_valid) begin
         slot_o = 2'b00;
      end else begin
         case (addr_page_i)
            2'd0:    slot_o = port_a_i[1:0];
            2'd1:    slot_o = port_a_i[3:2];
            2'd2:    slot_o = port_a_i[5:4];
            default: slot_o = port_a_i[7:6];
         endcase
      end
   end

endmodule

// File: logic/ppi_8255.sv
module ppi_8255 (
   input  logic                clk21m,
   input  logic                exwait_n,
   input  msx_pkg::cpu_bus_t   cpu_bus_i,
   input  logic                sel_i,
   input  msx_pkg::data_t      kb_data_i,
   output msx_pkg::data_t      data_o,
   output msx_pkg::data_t      port_a_o,
   output msx_pkg::ppi_ctrl_t  ctrl_o
);

   msx_pkg::data_t port_a;
   msx_pkg::data_t port_c;
   logic [1:0]     offset;
   logic           wr_done;
   logic           wr_stb;

   assign offset = cpu_bus_i.addr[1:0];

   // One write per access, rearmed once wr drops
   assign wr_stb = cpu_bus_i.wr & sel_i & ~wr_done;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wr_done <= 1'b0;
      end else if (!cpu_bus_i.wr) begin
         wr_done <= 1'b0;
      end else if (sel_i) begin
         wr_done <= 1'b1;
      end
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a <= '0;
         port_c <= '0;
      end else if (wr_stb) begin
         case (offset)
            2'd0: begin
               port_a <= cpu_bus_i.dout;
            end
            2'd2: begin
               port_c <= cpu_bus_i.dout;
            end
            2'd3: begin
               // Bit set/reset; mode words are ignored
               if (!cpu_bus_i.dout[7]) begin
                  port_c[cpu_bus_i.dout[3:1]] <= cpu_bus_i.dout[0];
               end
            end
            default: begin
            end
         endcase
      end
   end

   // Port B is the keyboard row input
   always_comb begin
      case (offset)
         2'd0:    data_o = port_a;
         2'd1:    data_o = kb_data_i;
         2'd2:    data_o = port_c;
         default: data_o = 8'hFF;
      endcase
   end

   assign port_a_o = port_a;

   assign ctrl_o.kb_row    = port_c[3:0];
   assign ctrl_o.cas_motor = port_c[4];
   assign ctrl_o.key_click = port_c[7];

endmodule

// File: logic/io_port_decoder.sv
module io_port_decoder (
   input  logic               clk21m,
   input  logic               exwait_n,
   input  msx_pkg::cpu_bus_t  cpu_bus_i,
   input  msx_pkg::data_t     vdp_data_i,
   input  msx_pkg::data_t     psg_data_i,
   input  msx_pkg::data_t     ppi_data_i,
   input  msx_pkg::data_t     mem_data_i,
   output msx_pkg::io_sel_t   io_sel_o,
   output logic               vdp_req_o,
   output msx_pkg::data_t     cpu_data_o
);

   msx_pkg::io_sel_t   io_sel;
   msx_pkg::port_base_t port_hi;
   logic               io_cycle;
   logic               bus_active;
   logic               req;
   logic               iack;

   // Interrupt acknowledge (iorq with m1) never selects a port
   assign port_hi  = cpu_bus_i.addr[7:3];
   assign io_cycle = cpu_bus_i.iorq & ~cpu_bus_i.m1;

   assign io_sel.psg = io_cycle && (port_hi == msx_pkg::PSG_PORT_BASE);
   assign io_sel.ppi = io_cycle && (port_hi == msx_pkg::PPI_PORT_BASE);
   assign io_sel.vdp = io_cycle && (port_hi == msx_pkg::VDP_PORT_BASE);

   assign io_sel_o = io_sel;

   assign bus_active = cpu_bus_i.iorq | cpu_bus_i.mreq;

   // Request is live only in the first cycle of an access
   assign req = bus_active & (cpu_bus_i.rd | cpu_bus_i.wr) & ~iack;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         iack <= 1'b0;
      end else if (!bus_active) begin
         iack <= 1'b0;
      end else if (req) begin
         iack <= 1'b1;
      end
   end

   assign vdp_req_o = req & io_sel.vdp;

   // CPU read data, highest priority first
   always_comb begin
      if (!cpu_bus_i.rd) begin
         cpu_data_o = 8'hFF;
      end else if (io_sel.vdp) begin
         cpu_data_o = vdp_data_i;
      end else if (io_sel.psg) begin
         cpu_data_o = psg_data_i;
      end else if (io_sel.ppi) begin
         cpu_data_o = ppi_data_i;
      end else begin
         cpu_data_o = mem_data_i;
      end
   end

endmodule

// File: logic/msx_pkg.sv
package msx_pkg;

   // Plain vector types of the CPU bus and the glue
   typedef logic [15:0]        addr_t;
   typedef logic [7:0]         data_t;
   typedef logic [1:0]         slot_t;
   typedef logic [3:0]         kb_row_t;
   typedef logic [4:0]         port_base_t;
   typedef logic [9:0]         psg_level_t;
   typedef logic signed [15:0] sample_t;

   // CPU bus, strobes active high
   typedef struct packed {
      addr_t addr;
      data_t dout;
      logic  mreq;
      logic  iorq;
      logic  rd;
      logic  wr;
      logic  m1;
   } cpu_bus_t;

   // Decoded I/O selects
   typedef struct packed {
      logic psg;
      logic ppi;
      logic vdp;
   } io_sel_t;

   // PPI port C outputs used outside the PPI
   typedef struct packed {
      kb_row_t kb_row;
      logic    cas_motor;
      logic    key_click;
   } ppi_ctrl_t;

   // M1 wait generator states
   typedef enum logic [1:0] {
      WAIT_IDLE = 2'd0,
      WAIT_HOLD = 2'd1,
      WAIT_DONE = 2'd2
   } wait_state_t;

   // I/O port groups, address bits 7..3
   localparam port_base_t PSG_PORT_BASE = 5'b10100;
   localparam port_base_t PPI_PORT_BASE = 5'b10101;
   localparam port_base_t VDP_PORT_BASE = 5'b10011;

endpackage
